/* lightsGame.f */
+incdir+src
src/lightsGame_pkg.sv
src/moveDecode.sv
src/boardUpdate.sv
src/gameStatus.sv
src/lightsGame.sv
verification/lightsGameTb.sv

/* src/boardUpdate.sv */
`timescale 1ns/1ps
`include "lightsGame_params.svh"

module boardUpdate
(
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      start,
    input  lightsGame_pkg::quadrant_t quadrant0,
    input  lightsGame_pkg::quadrant_t quadrant1,
    input  lightsGame_pkg::quadrant_t quadrant2,
    input  lightsGame_pkg::quadrant_t quadrant3,
    input  lightsGame_pkg::moveOp_t   moveOp,
    output lightsGame_pkg::board_t    board
);

    localparam int boardSize = `BOARD_SIZE;
    localparam int quadSize  = `QUAD_SIZE;

    // group masks in opcode order starting at MOVE_G0
    localparam lightsGame_pkg::board_t groupMasks [`NUM_GROUPS] =
        '{`GROUP0_MASK, `GROUP1_MASK, `GROUP2_MASK, `GROUP3_MASK};

    lightsGame_pkg::board_t loadBoard;
    lightsGame_pkg::board_t ruleBoard;
    lightsGame_pkg::board_t groupMask;
    lightsGame_pkg::board_t moveBoard;

    // new value of a group cell from its right, up, down and left neighbours
    function automatic logic ruleNext(input logic [3:0] rudl);
        logic lit;
        case (rudl)
            4'b1110,
            4'b1100,
            4'b1010,
            4'b1001,
            4'b0101,
            4'b0001:
            begin
                lit = 1'b1;
            end
            default:
            begin
                lit = 1'b0;
            end
        endcase
        return lit;
    endfunction

    // quadrant 0 is top left, 1 bottom left, 2 top right and 3 bottom right
    always_comb
    begin
        for (int r = 0; r < quadSize; r++)
        begin
            for (int c = 0; c < quadSize; c++)
            begin
                loadBoard[r][c]                       = quadrant0[r*quadSize + c];
                loadBoard[r + quadSize][c]            = quadrant1[r*quadSize + c];
                loadBoard[r][c + quadSize]            = quadrant2[r*quadSize + c];
                loadBoard[r + quadSize][c + quadSize] = quadrant3[r*quadSize + c];
            end
        end
    end

    // the rule is evaluated for every cell from the current board
    // and the mask below picks which results are kept
    for (genvar r = 0; r < boardSize; r++)
    begin : gRow
        for (genvar c = 0; c < boardSize; c++)
        begin : gCol
            localparam int up    = (r + boardSize - 1) % boardSize;
            localparam int down  = (r + 1) % boardSize;
            localparam int left  = (c + boardSize - 1) % boardSize;
            localparam int right = (c + 1) % boardSize;

            assign ruleBoard[r][c] = ruleNext({board[r][right], board[up][c],
                                               board[down][c], board[r][left]});
        end
    end

    always_comb
    begin
        case (moveOp)
            lightsGame_pkg::MOVE_G0:
            begin
                groupMask = `GROUP0_MASK;
            end
            lightsGame_pkg::MOVE_G1:
            begin
                groupMask = `GROUP1_MASK;
            end
            lightsGame_pkg::MOVE_G2:
            begin
                groupMask = `GROUP2_MASK;
            end
            lightsGame_pkg::MOVE_G3:
            begin
                groupMask = `GROUP3_MASK;
            end
            default:
            begin
                groupMask = '0;
            end
        endcase
    end

    // with no move pending the mask is empty and the board keeps its value
    assign moveBoard = (board & ~groupMask) | (ruleBoard & groupMask);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            board <= '0;
        end
        else if (start)
        begin
            board <= loadBoard;
        end
        else
        begin
            board <= moveBoard;
        end
    end

    // a move only ever touches the cells of its own group
    aKeepOutsideGroup: assert property (
        @(posedge clk) disable iff (!arstN)
        (!start && moveOp != lightsGame_pkg::MOVE_NONE)
            |=> (((board ^ $past(board)) & ~groupMasks[int'($past(moveOp)) - 1]) == '0)
    );

endmodule

/* src/gameStatus.sv */
`timescale 1ns/1ps
`include "lightsGame_params.svh"

module gameStatus
(
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    start,
    input  lightsGame_pkg::moveOp_t moveOp,
    input  lightsGame_pkg::board_t  board,
    output lightsGame_pkg::count_t  moveCount,
    output logic                    gameFinished
);

    localparam int blinkPeriod = `BLINK_PERIOD;
    localparam int blinkWidth  = (blinkPeriod > 1) ? $clog2(blinkPeriod) : 1;

    lightsGame_pkg::gameState_t state;
    lightsGame_pkg::gameState_t nextState;
    lightsGame_pkg::count_t     storedCount;
    logic [blinkWidth-1:0]      blinkCount;
    logic                       blinkDark;
    logic                       boardDark;

    assign boardDark = (board == '0);

    // start always wins so a reload in any state begins a fresh game
    always_comb
    begin
        nextState = state;
        case (state)
            lightsGame_pkg::IDLE:
            begin
                if (start)
                begin
                    nextState = lightsGame_pkg::PLAYING;
                end
            end
            lightsGame_pkg::PLAYING:
            begin
                if (!start && boardDark)
                begin
                    nextState = lightsGame_pkg::FINISHED;
                end
            end
            lightsGame_pkg::FINISHED:
            begin
                if (start)
                begin
                    nextState = lightsGame_pkg::PLAYING;
                end
            end
            default:
            begin
                nextState = lightsGame_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state       <= lightsGame_pkg::IDLE;
            storedCount <= '0;
        end
        else
        begin
            state <= nextState;
            if (start)
            begin
                storedCount <= '0;
            end
            // the move reaches the board in this same cycle
            else if (state == lightsGame_pkg::PLAYING && moveOp != lightsGame_pkg::MOVE_NONE)
            begin
                storedCount <= storedCount + 1'b1;
            end
        end
    end

    // blink timer only runs once the game is over
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            blinkCount <= '0;
            blinkDark  <= 1'b0;
        end
        else if (start || !gameFinished)
        begin
            blinkCount <= '0;
            blinkDark  <= 1'b0;
        end
        else if (blinkCount == blinkWidth'(blinkPeriod - 1))
        begin
            blinkCount <= '0;
            blinkDark  <= ~blinkDark;
        end
        else
        begin
            blinkCount <= blinkCount + 1'b1;
        end
    end

    assign gameFinished = (state == lightsGame_pkg::FINISHED);
    assign moveCount    = blinkDark ? '0 : storedCount;

    // once finished the count is frozen until the next load
    aFrozenCount: assert property (
        @(posedge clk) disable iff (!arstN)
        (gameFinished && !start) |=> $stable(storedCount)
    );

    // moves cannot light a dark board, so it stays dark for the whole finished phase
    aDarkWhileFinished: assert property (
        @(posedge clk) disable iff (!arstN)
        gameFinished |-> boardDark
    );

endmodule

/* src/lightsGame.sv */
`timescale 1ns/1ps

module lightsGame
(
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      start,
    input  logic                      button0,
    input  logic                      button1,
    input  logic                      button2,
    input  logic                      button3,
    input  lightsGame_pkg::quadrant_t quadrant0,
    input  lightsGame_pkg::quadrant_t quadrant1,
    input  lightsGame_pkg::quadrant_t quadrant2,
    input  lightsGame_pkg::quadrant_t quadrant3,
    output lightsGame_pkg::board_t    board,
    output lightsGame_pkg::count_t    moveCount,
    output logic                      gameFinished
);

    lightsGame_pkg::moveOp_t moveOp;

    // turns button edges into one registered move per cycle
    moveDecode decode0
    (
        .clk     (clk),
        .arstN   (arstN),
        .button0 (button0),
        .button1 (button1),
        .button2 (button2),
        .button3 (button3),
        .moveOp  (moveOp)
    );

    boardUpdate execute0
    (
        .clk       (clk),
        .arstN     (arstN),
        .start     (start),
        .quadrant0 (quadrant0),
        .quadrant1 (quadrant1),
        .quadrant2 (quadrant2),
        .quadrant3 (quadrant3),
        .moveOp    (moveOp),
        .board     (board)
    );

    // counts moves and watches the board for the end of the game
    gameStatus result0
    (
        .clk          (clk),
        .arstN        (arstN),
        .start        (start),
        .moveOp       (moveOp),
        .board        (board),
        .moveCount    (moveCount),
        .gameFinished (gameFinished)
    );

endmodule

/* src/lightsGame_params.svh */
`ifndef LIGHTSGAME_PARAMS_SVH
`define LIGHTSGAME_PARAMS_SVH

// the board is square and wraps around on both axes
`define BOARD_SIZE 8

// each load register covers one square quarter of the board
`define QUAD_SIZE 4

`define COUNT_WIDTH 16

`define NUM_GROUPS 4

// cycles spent in each phase of the finished display
// this is kept short for simulation and is raised for a real clock
`define BLINK_PERIOD 8

// group masks are written row 0 first and column 0 first in every row
// a one marks a cell that takes part in the move of that group
`define GROUP0_MASK 64'b00000101_10100000_00000101_10100000_01010000_00000101_01010000_00000101

`define GROUP1_MASK 64'b00001010_01010000_00001010_01010000_10100000_00001010_10100000_00001010

`define GROUP2_MASK 64'b01010000_00000101_01010000_00000101_00001010_01010000_00001010_01010000

`define GROUP3_MASK 64'b10100000_00001010_10100000_00001010_00000101_10100000_00000101_10100000

`endif

/* src/lightsGame_pkg.sv */
`include "lightsGame_params.svh"

package lightsGame_pkg;

    // row-major grid indexed as [row][column]
    // both ranges ascend so row 0 and column 0 sit at the most significant end,
    // which lets a mask literal be read in the same order as the board
    typedef logic [0:`BOARD_SIZE-1][0:`BOARD_SIZE-1] board_t;

    // bit i of a quadrant is local row i/4 and local column i%4
    typedef logic [`QUAD_SIZE*`QUAD_SIZE-1:0] quadrant_t;

    typedef logic [`COUNT_WIDTH-1:0] count_t;

    // one opcode per push button with MOVE_G0 belonging to button 0
    typedef enum logic [2:0]
    {
        MOVE_NONE,
        MOVE_G0,
        MOVE_G1,
        MOVE_G2,
        MOVE_G3
    } moveOp_t;

    typedef enum logic [1:0]
    {
        IDLE,
        PLAYING,
        FINISHED
    } gameState_t;

endpackage

/* src/moveDecode.sv */
`timescale 1ns/1ps
`include "lightsGame_params.svh"

module moveDecode
(
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    button0,
    input  logic                    button1,
    input  logic                    button2,
    input  logic                    button3,
    output lightsGame_pkg::moveOp_t moveOp
);

    logic [`NUM_GROUPS-1:0]  buttons;
    logic [`NUM_GROUPS-1:0]  buttonsPrev;
    logic [`NUM_GROUPS-1:0]  rise;
    lightsGame_pkg::moveOp_t nextOp;

    assign buttons = {button3, button2, button1, button0};

    // a button counts only in the cycle it goes from low to high
    assign rise = buttons & ~buttonsPrev;

    // the loop runs down towards button 0 so the lowest rising button is the one kept
    always_comb
    begin
        nextOp = lightsGame_pkg::MOVE_NONE;
        for (int i = `NUM_GROUPS - 1; i >= 0; i--)
        begin
            if (rise[i])
            begin
                nextOp = lightsGame_pkg::moveOp_t'(i + 1);
            end
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            buttonsPrev <= '0;
            moveOp      <= lightsGame_pkg::MOVE_NONE;
        end
        else
        begin
            buttonsPrev <= buttons;
            moveOp      <= nextOp;
        end
    end

    // a held button must not issue its move again
    aSingleMove: assert property (
        @(posedge clk) disable iff (!arstN)
        (moveOp != lightsGame_pkg::MOVE_NONE && (buttons & ~$past(buttons)) == '0)
            |=> (moveOp == lightsGame_pkg::MOVE_NONE)
    );

endmodule

/* verification/lightsGameTb.sv */
`timescale 1ns/1ps
`include "lightsGame_params.svh"

module lightsGameTb;

    // the stimulus below needs well under a thousand cycles
    localparam int timeoutCycles = 3000;

    logic                       clk = 1'b1;
    logic                       arstN;
    logic                       start;
    logic [3:0]                 buttons;
    lightsGame_pkg::quadrant_t  quad0;
    lightsGame_pkg::quadrant_t  quad1;
    lightsGame_pkg::quadrant_t  quad2;
    lightsGame_pkg::quadrant_t  quad3;
    lightsGame_pkg::board_t     board;
    lightsGame_pkg::count_t     moveCount;
    logic                       gameFinished;

    // reference model of the game that updates on the same edges as the DUT
    logic [3:0]                 modelPrevButtons;
    int                         modelOp;
    lightsGame_pkg::board_t     modelBoard;
    lightsGame_pkg::count_t     modelCount;
    lightsGame_pkg::gameState_t modelState;
    int                         modelBlinkCycles;
    lightsGame_pkg::count_t     expectedCount;
    logic                       expectedFinished;

    logic [31:0]                lfsrState = 32'd79897;
    int                         cycleCount = 0;
    logic                       blinkSeen = 1'b0;

    always #5 clk = ~clk;

    lightsGame dut0
    (
        .clk          (clk),
        .arstN        (arstN),
        .start        (start),
        .button0      (buttons[0]),
        .button1      (buttons[1]),
        .button2      (buttons[2]),
        .button3      (buttons[3]),
        .quadrant0    (quad0),
        .quadrant1    (quad1),
        .quadrant2    (quad2),
        .quadrant3    (quad3),
        .board        (board),
        .moveCount    (moveCount),
        .gameFinished (gameFinished)
    );

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic takeBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    function automatic lightsGame_pkg::board_t mapQuadrants(input logic [15:0] q0,
        input logic [15:0] q1, input logic [15:0] q2, input logic [15:0] q3);
        lightsGame_pkg::board_t b;
        int r;
        int c;
        for (int i = 0; i < `QUAD_SIZE * `QUAD_SIZE; i++)
        begin
            r = i / `QUAD_SIZE;
            c = i % `QUAD_SIZE;
            b[r][c] = q0[i];
            b[r + `QUAD_SIZE][c] = q1[i];
            b[r][c + `QUAD_SIZE] = q2[i];
            b[r + `QUAD_SIZE][c + `QUAD_SIZE] = q3[i];
        end
        return b;
    endfunction

    // every masked cell looks at its right, up, down and left neighbour on the torus
    function automatic lightsGame_pkg::board_t neighbourRule(input lightsGame_pkg::board_t b,
        input lightsGame_pkg::board_t mask);
        lightsGame_pkg::board_t next;
        logic [3:0] rudl;
        int n;
        n = `BOARD_SIZE;
        next = b;
        for (int r = 0; r < n; r++)
        begin
            for (int c = 0; c < n; c++)
            begin
                if (mask[r][c])
                begin
                    rudl = {b[r][(c + 1) % n], b[(r + n - 1) % n][c],
                            b[(r + 1) % n][c], b[r][(c + n - 1) % n]};
                    next[r][c] = rudl inside {4'b1110, 4'b1100, 4'b1010,
                                              4'b1001, 4'b0101, 4'b0001};
                end
            end
        end
        return next;
    endfunction

    function automatic lightsGame_pkg::board_t maskForMove(input int op);
        case (op)
            1: return `GROUP0_MASK;
            2: return `GROUP1_MASK;
            3: return `GROUP2_MASK;
            4: return `GROUP3_MASK;
            default: return '0;
        endcase
    endfunction

    // button 0 has the highest priority and moves are numbered from 1
    function automatic int firstRisingMove(input logic [3:0] rise);
        for (int i = 0; i < 4; i++)
        begin
            if (rise[i])
            begin
                return i + 1;
            end
        end
        return 0;
    endfunction

    always @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            modelPrevButtons <= '0;
            modelOp          <= 0;
            modelBoard       <= '0;
            modelCount       <= '0;
            modelState       <= lightsGame_pkg::IDLE;
            modelBlinkCycles <= 0;
        end
        else
        begin
            modelPrevButtons <= buttons;
            modelOp          <= firstRisingMove(buttons & ~modelPrevButtons);
            if (start)
            begin
                modelBoard <= mapQuadrants(quad0, quad1, quad2, quad3);
                modelCount <= '0;
            end
            else if (modelOp != 0)
            begin
                modelBoard <= neighbourRule(modelBoard, maskForMove(modelOp));
                if (modelState == lightsGame_pkg::PLAYING)
                begin
                    modelCount <= modelCount + 1'b1;
                end
            end
            if (start)
            begin
                modelState <= lightsGame_pkg::PLAYING;
            end
            else if (modelState == lightsGame_pkg::PLAYING && modelBoard == '0)
            begin
                modelState <= lightsGame_pkg::FINISHED;
            end
            if (start || modelState != lightsGame_pkg::FINISHED)
            begin
                modelBlinkCycles <= 0;
            end
            else
            begin
                modelBlinkCycles <= modelBlinkCycles + 1;
            end
        end
    end

    // odd blink phases show zero instead of the frozen count
    assign expectedFinished = (modelState == lightsGame_pkg::FINISHED);
    assign expectedCount = (expectedFinished && (modelBlinkCycles / `BLINK_PERIOD) % 2 == 1)
                           ? '0 : modelCount;

    task automatic reportMismatch(input string name, input logic [63:0] expected,
        input logic [63:0] actual);
        $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        $display("Finished with errors");
        $fatal(1, "%s does not match the model", name);
    endtask

    boardMatches: assert property (@(posedge clk) board == modelBoard)
        else reportMismatch("board", $sampled(modelBoard), $sampled(board));

    countMatches: assert property (@(posedge clk) moveCount == expectedCount)
        else reportMismatch("moveCount", $sampled(expectedCount), $sampled(moveCount));

    finishedMatches: assert property (@(posedge clk) gameFinished == expectedFinished)
        else reportMismatch("gameFinished", $sampled(expectedFinished), $sampled(gameFinished));

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutCycles)
        begin
            $display("Timeout: the run did not end within %0d cycles", timeoutCycles);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    // the dark half of the blink only shows when the frozen count is not zero
    always @(negedge clk)
    begin
        if (gameFinished && moveCount == '0 && modelCount != '0)
        begin
            blinkSeen = 1'b1;
        end
    end

    task automatic loadQuadrants(input logic [15:0] q0, input logic [15:0] q1,
        input logic [15:0] q2, input logic [15:0] q3);
        quad0 = q0;
        quad1 = q1;
        quad2 = q2;
        quad3 = q3;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        @(negedge clk);
    endtask

    task automatic loadRandomBoard();
        logic [31:0] q0;
        logic [31:0] q1;
        logic [31:0] q2;
        logic [31:0] q3;
        takeBits(16, q0);
        takeBits(16, q1);
        takeBits(16, q2);
        takeBits(16, q3);
        loadQuadrants(q0[15:0], q1[15:0], q2[15:0], q3[15:0]);
    endtask

    // called on a falling edge and returns one cycle after the release
    task automatic pressButtons(input logic [3:0] pressed, input int holdCycles);
        buttons = pressed;
        repeat (holdCycles) @(negedge clk);
        buttons = '0;
        @(negedge clk);
    endtask

    task automatic waitForFinish();
        while (!gameFinished)
        begin
            @(negedge clk);
        end
    endtask

    initial
    begin
        logic [31:0] pick;
        arstN   = 1'b1;
        start   = 1'b0;
        buttons = '0;
        quad0   = '0;
        quad1   = '0;
        quad2   = '0;
        quad3   = '0;
        @(negedge clk);
        arstN = 1'b0;
        repeat (4) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        for (int i = 0; i < 40; i++)
        begin
            if (i % 10 == 0)
            begin
                loadRandomBoard();
            end
            takeBits(2, pick);
            pressButtons(4'b0001 << pick[1:0], 1);
        end

        // simultaneous edges and a long hold
        loadRandomBoard();
        pressButtons(4'b0110, 1);
        pressButtons(4'b1001, 1);
        pressButtons(4'b0100, 6);

        // a dark load finishes at once and moves are ignored
        loadQuadrants('0, '0, '0, '0);
        waitForFinish();
        pressButtons(4'b0001, 1);
        pressButtons(4'b1000, 1);

        // one lit cell at row 0 column 5 is cleared by a single group 0 move
        loadQuadrants('0, '0, 16'h0002, '0);
        pressButtons(4'b0001, 1);
        waitForFinish();
        repeat (2 * `BLINK_PERIOD) @(negedge clk);
        pressButtons(4'b0010, 1);
        repeat (2 * `BLINK_PERIOD) @(negedge clk);

        loadRandomBoard();
        pressButtons(4'b0001, 1);
        repeat (3) @(negedge clk);

        if (!blinkSeen)
        begin
            $display("The blinking display of a frozen count was never observed");
            $display("Finished with errors");
            $fatal(1, "blink phase not reached");
        end
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule
